/* verilog.f */
lsu_pkg.sv
lsu_dccm_mem.sv
lsu_addr_gen.sv
lsu_store_buffer.sv
lsu_dccm_ctl.sv
lsu_top.sv
tb_lsu.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the LSU simulation with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_lsu -f verilog.f -o sim_lsu
./obj_dir/sim_lsu | tee sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
   exit 1
fi
exit 0

/* tb_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;

   localparam int CYCLE_LIMIT = 5000;   // About 600 operations at up to 6 cycles plus margin
   localparam int RANDOM_OPS  = 400;
   localparam int DRAIN_LIMIT = 20;

   logic                    clk;
   logic                    arst_n;
   logic                    lsu_valid;
   logic                    lsu_load;
   logic                    lsu_store;
   lsu_pkg::access_size_t   lsu_size;
   logic                    lsu_unsign;
   lsu_pkg::addr_t          lsu_rs1;
   lsu_pkg::offset_t        lsu_offset;
   lsu_pkg::data_t          lsu_store_data;
   logic                    lsu_result_valid;
   lsu_pkg::data_t          lsu_result;
   lsu_pkg::lsu_error_t     lsu_error;
   logic                    lsu_store_stall;
   logic                    lsu_idle;

   logic [7:0]              ref_mem [2 ** lsu_pkg::DCCM_BITS];   // Byte image of the DCCM
   lsu_pkg::data_t          exp_data_q [$];
   lsu_pkg::lsu_error_t     exp_err_q [$];
   int                      exp_cycle_q [$];
   logic [15:0]             lfsr = 16'd26;
   logic                    idle_seen = 1'b0;
   int                      cycle_count = 0;
   int                      checks = 0;
   int                      errors = 0;
   int                      stall_cycles = 0;
   int                      test_checks = 0;
   int                      test_errors = 0;

   lsu_top i_dut (
      .clk, .arst_n, .lsu_valid, .lsu_load, .lsu_store, .lsu_size, .lsu_unsign,
      .lsu_rs1, .lsu_offset, .lsu_store_data,
      .lsu_result_valid, .lsu_result, .lsu_error, .lsu_store_stall, .lsu_idle
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Cycle count and run limit
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout after %0d cycles, the run did not finish", cycle_count);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // ****************************************
   // Reference model
   // ****************************************

   function automatic int size_bytes(input lsu_pkg::access_size_t size);
      case (size)
         lsu_pkg::size_byte: return 1;
         lsu_pkg::size_half: return 2;
         default:            return 4;
      endcase
   endfunction

   function automatic lsu_pkg::addr_t eff_addr(input lsu_pkg::addr_t rs1,
                                               input lsu_pkg::offset_t off);
      return rs1 + lsu_pkg::addr_t'(int'(off));
   endfunction

   // Fill value mixes all address bits
   function automatic lsu_pkg::data_t fill_word(input lsu_pkg::addr_t a);
      return (a * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
   endfunction

   function automatic void expected_result(input logic ld, input lsu_pkg::access_size_t size,
                                           input logic uns, input lsu_pkg::addr_t rs1,
                                           input lsu_pkg::offset_t off,
                                           output lsu_pkg::data_t res,
                                           output lsu_pkg::lsu_error_t err);
      lsu_pkg::addr_t a;
      int             nbytes;
      int             base;
      a      = eff_addr(rs1, off);
      nbytes = size_bytes(size);
      base   = int'(a[lsu_pkg::DCCM_BITS-1:0]);
      res    = '0;
      if ((base % nbytes) != 0) begin
         err = lsu_pkg::err_misaligned;
      end else if ((a - lsu_pkg::DCCM_BASE) >= 32'(2 ** lsu_pkg::DCCM_BITS)) begin
         err = lsu_pkg::err_range;   // Below the base or past the 4 KiB window
      end else begin
         err = lsu_pkg::err_none;
      end
      if (ld && err == lsu_pkg::err_none) begin
         for (int i = 0; i < nbytes; i++) begin
            res[8*i +: 8] = ref_mem[base + i];
         end
         for (int i = nbytes; i < 4; i++) begin   // Upper bytes from the sign or zero
            res[8*i +: 8] = (!uns && res[8*nbytes-1]) ? 8'hFF : 8'h00;
         end
      end
   endfunction

   task automatic update_ref(input lsu_pkg::access_size_t size, input lsu_pkg::addr_t a,
                             input lsu_pkg::data_t wdata);
      int base;
      base = int'(a[lsu_pkg::DCCM_BITS-1:0]);
      for (int i = 0; i < size_bytes(size); i++) begin
         ref_mem[base + i] = wdata[8*i +: 8];
      end
   endtask

   // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   // ****************************************
   // Stimulus helpers
   // ****************************************

   task automatic issue_request(input logic ld, input logic st, input lsu_pkg::access_size_t size,
                                input logic uns, input lsu_pkg::addr_t rs1,
                                input lsu_pkg::offset_t off, input lsu_pkg::data_t wdata);
      lsu_pkg::data_t      exp_data;
      lsu_pkg::lsu_error_t exp_err;
      @(negedge clk);
      while (st && lsu_store_stall) begin   // Hold stores back while the buffer is nearly full
         @(posedge clk);
         lsu_valid <= 1'b0;
         @(negedge clk);
      end
      @(posedge clk);
      lsu_valid      <= 1'b1;
      lsu_load       <= ld;
      lsu_store      <= st;
      lsu_size       <= size;
      lsu_unsign     <= uns;
      lsu_rs1        <= rs1;
      lsu_offset     <= off;
      lsu_store_data <= wdata;
      expected_result(ld, size, uns, rs1, off, exp_data, exp_err);
      exp_data_q.push_back(exp_data);
      exp_err_q.push_back(exp_err);
      exp_cycle_q.push_back(cycle_count + 3);   // Sampled at the next edge with the result two cycles on
      if (st && exp_err == lsu_pkg::err_none) begin
         update_ref(size, eff_addr(rs1, off), wdata);
      end
   endtask

   // Stop issuing and wait for all results and an empty buffer
   task automatic drain_pipeline();
      int waited;
      waited = 0;
      @(posedge clk);
      lsu_valid <= 1'b0;
      while ((exp_data_q.size() != 0 || !idle_seen) && waited < DRAIN_LIMIT) begin
         @(posedge clk);
         waited++;
      end
      checks++;
      if (exp_data_q.size() != 0) begin
         $display("%0d expected results never arrived", exp_data_q.size());
         errors++;
         exp_data_q.delete();
         exp_err_q.delete();
         exp_cycle_q.delete();
      end else if (!idle_seen) begin
         $display("lsu_idle did not return high after the last request");
         errors++;
      end
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic finish_test(input string name);
      $display("%s: %0d checks, %0d errors", name, checks - test_checks, errors - test_errors);
      test_checks = checks;
      test_errors = errors;
   endtask

   // ****************************************
   // Result checker
   // ****************************************

   always @(negedge clk) begin : check_results
      lsu_pkg::data_t      exp_data;
      lsu_pkg::lsu_error_t exp_err;
      int                  exp_cycle;
      idle_seen = lsu_idle;
      if (lsu_store_stall) begin
         stall_cycles++;
      end
      if (arst_n && lsu_result_valid) begin
         if (exp_data_q.size() == 0) begin
            $display("result at %0t arrived but no request expected one", $time);
            errors++;
         end else begin
            exp_data  = exp_data_q.pop_front();
            exp_err   = exp_err_q.pop_front();
            exp_cycle = exp_cycle_q.pop_front();
            checks++;
            if (lsu_result !== exp_data) begin
               $display("error at %0t: lsu_result is %08h, expected %08h",
                        $time, lsu_result, exp_data);
               errors++;
            end
            if (lsu_error !== exp_err) begin
               $display("error at %0t: lsu_error is %s, expected %s",
                        $time, lsu_error.name(), exp_err.name());
               errors++;
            end
            if (cycle_count != exp_cycle) begin
               $display("error at %0t: lsu_result_valid cycle is %0d, expected %0d",
                        $time, cycle_count, exp_cycle);
               errors++;
            end
            if (lsu_idle !== 1'b0) begin   // A request still sits in r
               $display("error at %0t: lsu_idle is %b, expected %b",
                        $time, lsu_idle, 1'b0);
               errors++;
            end
         end
      end
   end

   // ****************************************
   // Test sequence
   // ****************************************

   initial begin
      logic                  st;
      logic                  uns;
      logic [31:0]           sel;
      logic [31:0]           lo;
      logic [31:0]           widx;
      lsu_pkg::data_t        wdata;
      lsu_pkg::access_size_t size;
      lsu_pkg::addr_t        base;
      int                    byte_addr;

      arst_n         = 1'b0;
      lsu_valid      = 1'b0;
      lsu_load       = 1'b0;
      lsu_store      = 1'b0;
      lsu_size       = lsu_pkg::size_word;
      lsu_unsign     = 1'b0;
      lsu_rs1        = '0;
      lsu_offset     = '0;
      lsu_store_data = '0;
      base           = lsu_pkg::DCCM_BASE;

      repeat (2) @(posedge clk);
      @(negedge clk);
      compare_bit("lsu_result_valid", lsu_result_valid, 1'b0);
      compare_bit("lsu_store_stall", lsu_store_stall, 1'b0);
      compare_bit("lsu_idle", lsu_idle, 1'b1);
      @(posedge clk);
      arst_n <= 1'b1;
      finish_test("reset values");

      // Fill words 0 to 31 and read them back through negative offsets
      for (int i = 0; i < 32; i++) begin
         issue_request(1'b0, 1'b1, lsu_pkg::size_word, 1'b0, base,
                       lsu_pkg::offset_t'(i * 4), fill_word(base + 32'(i * 4)));
      end
      drain_pipeline();
      for (int i = 0; i < 32; i++) begin
         issue_request(1'b1, 1'b0, lsu_pkg::size_word, 1'b0, base + 32'd128,
                       lsu_pkg::offset_t'(i * 4 - 128), '0);
      end
      drain_pipeline();
      finish_test("test 1 word store and load");

      for (int w = 0; w < 4; w++) begin
         for (int u = 0; u < 2; u++) begin
            for (int b = 0; b < 4; b++) begin
               issue_request(1'b1, 1'b0, lsu_pkg::size_byte, u[0], base,
                             lsu_pkg::offset_t'(w * 4 + b), '0);
            end
            for (int h = 0; h < 4; h += 2) begin
               issue_request(1'b1, 1'b0, lsu_pkg::size_half, u[0], base,
                             lsu_pkg::offset_t'(w * 4 + h), '0);
            end
         end
      end
      drain_pipeline();
      finish_test("test 2 byte and half extension");

      // Each load follows its store directly
      issue_request(1'b0, 1'b1, lsu_pkg::size_byte, 1'b0, base, 12'sd26, 32'h0000_00C7);
      issue_request(1'b1, 1'b0, lsu_pkg::size_word, 1'b0, base, 12'sd24, '0);
      issue_request(1'b0, 1'b1, lsu_pkg::size_word, 1'b0, base, 12'sd20, 32'h1122_3344);
      issue_request(1'b1, 1'b0, lsu_pkg::size_word, 1'b0, base, 12'sd20, '0);
      issue_request(1'b0, 1'b1, lsu_pkg::size_byte, 1'b0, base, 12'sd21, 32'h0000_00AB);
      issue_request(1'b1, 1'b0, lsu_pkg::size_half, 1'b0, base, 12'sd20, '0);
      issue_request(1'b0, 1'b1, lsu_pkg::size_half, 1'b0, base, 12'sd22, 32'h0000_8001);
      issue_request(1'b1, 1'b0, lsu_pkg::size_word, 1'b0, base, 12'sd20, '0);
      issue_request(1'b0, 1'b1, lsu_pkg::size_byte, 1'b0, base, 12'sd23, 32'h0000_0055);
      issue_request(1'b0, 1'b1, lsu_pkg::size_byte, 1'b0, base, 12'sd23, 32'h0000_0066);
      issue_request(1'b1, 1'b0, lsu_pkg::size_byte, 1'b1, base, 12'sd23, '0);
      issue_request(1'b1, 1'b0, lsu_pkg::size_half, 1'b0, base, 12'sd22, '0);
      drain_pipeline();
      finish_test("test 3 store to load forwarding");

      issue_request(1'b1, 1'b0, lsu_pkg::size_half, 1'b0, base, 12'sd1, '0);
      issue_request(1'b1, 1'b0, lsu_pkg::size_word, 1'b0, base, 12'sd6, '0);
      issue_request(1'b1, 1'b0, lsu_pkg::size_word, 1'b0, base + 32'h1000, 12'sd8, '0);
      issue_request(1'b1, 1'b0, lsu_pkg::size_word, 1'b0, base, -12'sd4, '0);
      issue_request(1'b1, 1'b0, lsu_pkg::size_half, 1'b0, base + 32'h1000, 12'sd3, '0);
      issue_request(1'b0, 1'b1, lsu_pkg::size_word, 1'b0, base + 32'h1000, 12'sd8, 32'hDEAD_BEEF);
      issue_request(1'b0, 1'b1, lsu_pkg::size_word, 1'b0, base, 12'sd10, 32'hCAFE_F00D);
      issue_request(1'b0, 1'b1, lsu_pkg::size_half, 1'b0, base, 12'sd9, 32'h0000_BEEF);
      issue_request(1'b1, 1'b0, lsu_pkg::size_word, 1'b0, base, 12'sd8, '0);
      issue_request(1'b1, 1'b0, lsu_pkg::size_word, 1'b0, base, 12'sd12, '0);
      drain_pipeline();
      finish_test("test 4 misaligned and out of window");

      // Random mix over words 16 to 31 with offsets around a base in the middle
      stall_cycles = 0;
      for (int n = 0; n < RANDOM_OPS; n++) begin
         st    = rand_bits(1) != 0;
         sel   = rand_bits(2);
         uns   = rand_bits(1) != 0;
         widx  = rand_bits(4);
         lo    = rand_bits(2);
         wdata = rand_bits(32);
         if (sel == 0) begin
            size = lsu_pkg::size_byte;
         end else if (sel == 1) begin
            size = lsu_pkg::size_half;
            lo   = lo & 32'd2;
         end else begin
            size = lsu_pkg::size_word;
            lo   = '0;
         end
         byte_addr = 64 + int'(widx) * 4 + int'(lo);
         issue_request(!st, st, size, uns, base + 32'd96,
                       lsu_pkg::offset_t'(byte_addr - 96), wdata);
      end
      drain_pipeline();
      compare_bit("lsu_store_stall", lsu_store_stall, 1'b0);
      $display("lsu_store_stall was high in %0d cycles", stall_cycles);
      finish_test("test 5 random loads and stores");

      $display("tests: 6, checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Load store unit with its private DCCM
module lsu_top (
   input  wire logic                clk,
   input  wire logic                arst_n,
   input  wire logic                lsu_valid,
   input  wire logic                lsu_load,
   input  wire logic                lsu_store,
   input  lsu_pkg::access_size_t    lsu_size,
   input  wire logic                lsu_unsign,
   input  lsu_pkg::addr_t           lsu_rs1,
   input  lsu_pkg::offset_t         lsu_offset,
   input  lsu_pkg::data_t           lsu_store_data,
   output logic                     lsu_result_valid,
   output lsu_pkg::data_t           lsu_result,
   output lsu_pkg::lsu_error_t      lsu_error,
   output logic                     lsu_store_stall,
   output logic                     lsu_idle
);

   // M stage request
   logic                      m_valid;
   logic                      m_load;
   logic                      m_store;
   lsu_pkg::access_size_t     m_size;
   logic                      m_unsign;
   lsu_pkg::addr_t            m_addr;
   lsu_pkg::data_t            m_store_data;
   lsu_pkg::lsu_error_t       m_error;

   // Store buffer side
   lsu_pkg::data_t            fwd_data;
   lsu_pkg::byte_en_t         fwd_byte_en;
   logic                      drain_valid;
   lsu_pkg::dccm_word_addr_t  drain_word_addr;
   lsu_pkg::data_t            drain_data;
   lsu_pkg::byte_en_t         drain_byte_en;
   logic                      drain_ack;
   logic                      stbuf_empty;

   // Memory port
   logic                      mem_en;
   logic                      mem_we;
   lsu_pkg::dccm_word_addr_t  mem_word_addr;
   lsu_pkg::data_t            mem_wdata;
   lsu_pkg::byte_en_t         mem_byte_en;
   lsu_pkg::data_t            mem_rdata;
   logic                      r_busy;

   // ****************************************
   // Pipeline blocks
   // ****************************************

   lsu_addr_gen i_addr_gen (
      .clk, .arst_n, .lsu_valid, .lsu_load, .lsu_store, .lsu_size, .lsu_unsign,
      .lsu_rs1, .lsu_offset, .lsu_store_data,
      .m_valid, .m_load, .m_store, .m_size, .m_unsign, .m_addr, .m_store_data, .m_error
   );

   lsu_store_buffer i_store_buffer (
      .clk, .arst_n, .m_valid, .m_store, .m_size, .m_addr, .m_store_data, .m_error,
      .fwd_data, .fwd_byte_en,
      .drain_valid, .drain_word_addr, .drain_data, .drain_byte_en, .drain_ack,
      .lsu_store_stall, .stbuf_empty
   );

   lsu_dccm_ctl i_dccm_ctl (
      .clk, .arst_n, .m_valid, .m_load, .m_size, .m_unsign, .m_addr, .m_error,
      .fwd_data, .fwd_byte_en,
      .drain_valid, .drain_word_addr, .drain_data, .drain_byte_en, .drain_ack,
      .mem_en, .mem_we, .mem_word_addr, .mem_wdata, .mem_byte_en, .mem_rdata,
      .lsu_result_valid, .lsu_result, .lsu_error, .r_busy
   );

   lsu_dccm_mem i_dccm_mem (
      .clk, .mem_en, .mem_we, .mem_word_addr, .mem_wdata, .mem_byte_en, .mem_rdata
   );

   // Nothing buffered and nothing in m or r
   assign lsu_idle = stbuf_empty & ~m_valid & ~r_busy;

endmodule

`default_nettype wire

/* lsu_dccm_ctl.sv */
`timescale 1ns/1ps
`default_nettype none

// DCCM port control and r stage result formatting
module lsu_dccm_ctl (
   input  wire logic                   clk,
   input  wire logic                   arst_n,
   input  wire logic                   m_valid,
   input  wire logic                   m_load,
   input  lsu_pkg::access_size_t       m_size,
   input  wire logic                   m_unsign,
   input  lsu_pkg::addr_t              m_addr,
   input  lsu_pkg::lsu_error_t         m_error,
   input  lsu_pkg::data_t              fwd_data,
   input  lsu_pkg::byte_en_t           fwd_byte_en,
   input  wire logic                   drain_valid,
   input  lsu_pkg::dccm_word_addr_t    drain_word_addr,
   input  lsu_pkg::data_t              drain_data,
   input  lsu_pkg::byte_en_t           drain_byte_en,
   output logic                        drain_ack,
   output logic                        mem_en,
   output logic                        mem_we,
   output lsu_pkg::dccm_word_addr_t    mem_word_addr,
   output lsu_pkg::data_t              mem_wdata,
   output lsu_pkg::byte_en_t           mem_byte_en,
   input  lsu_pkg::data_t              mem_rdata,
   output logic                        lsu_result_valid,
   output lsu_pkg::data_t              lsu_result,
   output lsu_pkg::lsu_error_t         lsu_error,
   output logic                        r_busy
);

   logic                   load_go;
   logic                   r_valid;
   logic                   r_load;
   lsu_pkg::access_size_t  r_size;
   logic                   r_unsign;
   logic [1:0]             r_addr_lo;
   lsu_pkg::lsu_error_t    r_error;
   lsu_pkg::data_t         r_fwd_data;
   lsu_pkg::byte_en_t      r_fwd_be;
   lsu_pkg::data_t         merged;
   lsu_pkg::data_t         shifted;
   lsu_pkg::data_t         extended;

   // ****************************************
   // Memory port arbitration
   // ****************************************

   assign load_go = m_valid & m_load & (m_error == lsu_pkg::err_none);

   assign mem_en        = load_go | drain_valid;
   assign mem_we        = ~load_go & drain_valid;   // Drain only when no load in m
   assign drain_ack     = mem_we;
   assign mem_word_addr = load_go ? m_addr[lsu_pkg::DCCM_BITS-1:2] : drain_word_addr;
   assign mem_wdata     = drain_data;
   assign mem_byte_en   = load_go ? 4'b1111 : drain_byte_en;

   // ****************************************
   // M to R register
   // ****************************************

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         r_valid <= 1'b0;
         r_load  <= 1'b0;
         r_error <= lsu_pkg::err_none;
      end else begin
         r_valid <= m_valid;
         r_load  <= load_go;
         r_error <= m_valid ? m_error : lsu_pkg::err_none;
      end
   end

   // Load formatting info, captured with the memory read
   always_ff @(posedge clk) begin
      if (load_go) begin
         r_size     <= m_size;
         r_unsign   <= m_unsign;
         r_addr_lo  <= m_addr[1:0];
         r_fwd_data <= fwd_data;
         r_fwd_be   <= fwd_byte_en;
      end
   end

   // Forwarded bytes take precedence over the array
   always_comb begin
      for (int b = 0; b < 4; b++) begin
         merged[8*b +: 8] = r_fwd_be[b] ? r_fwd_data[8*b +: 8] : mem_rdata[8*b +: 8];
      end
   end

   assign shifted = merged >> {r_addr_lo, 3'b000};

   always_comb begin
      case (r_size)
         lsu_pkg::size_byte: begin
            extended = r_unsign ? {24'b0, shifted[7:0]} : {{24{shifted[7]}}, shifted[7:0]};
         end
         lsu_pkg::size_half: begin
            extended = r_unsign ? {16'b0, shifted[15:0]} : {{16{shifted[15]}}, shifted[15:0]};
         end
         default: extended = shifted;
      endcase
   end

   assign lsu_result_valid = r_valid;
   assign lsu_result       = r_load ? extended : '0;   // Zero for stores and errors
   assign lsu_error        = r_error;
   assign r_busy           = r_valid;

endmodule

`default_nettype wire

/* lsu_store_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

// Store buffer between the m stage and the DCCM
// Stores enter at the m stage and drain in order when the memory port is free
module lsu_store_buffer (
   input  wire logic                   clk,
   input  wire logic                   arst_n,
   input  wire logic                   m_valid,
   input  wire logic                   m_store,
   input  lsu_pkg::access_size_t       m_size,
   input  lsu_pkg::addr_t              m_addr,
   input  lsu_pkg::data_t              m_store_data,
   input  lsu_pkg::lsu_error_t         m_error,
   output lsu_pkg::data_t              fwd_data,
   output lsu_pkg::byte_en_t           fwd_byte_en,
   output logic                        drain_valid,
   output lsu_pkg::dccm_word_addr_t    drain_word_addr,
   output lsu_pkg::data_t              drain_data,
   output lsu_pkg::byte_en_t           drain_byte_en,
   input  wire logic                   drain_ack,
   output logic                        lsu_store_stall,
   output logic                        stbuf_empty
);

   lsu_pkg::dccm_word_addr_t entry_addr [lsu_pkg::STBUF_DEPTH];
   lsu_pkg::data_t           entry_data [lsu_pkg::STBUF_DEPTH];
   lsu_pkg::byte_en_t        entry_be   [lsu_pkg::STBUF_DEPTH];

   lsu_pkg::stbuf_ptr_t      wr_ptr;
   lsu_pkg::stbuf_ptr_t      rd_ptr;
   lsu_pkg::stbuf_count_t    count;

   logic                     wr_en;
   lsu_pkg::dccm_word_addr_t m_word_addr;
   lsu_pkg::data_t           lane_data;
   lsu_pkg::byte_en_t        lane_be;

   assign wr_en       = m_valid & m_store & (m_error == lsu_pkg::err_none);
   assign m_word_addr = m_addr[lsu_pkg::DCCM_BITS-1:2];

   // ****************************************
   // Byte lane placement
   // ****************************************

   always_comb begin
      case (m_size)
         lsu_pkg::size_byte: begin
            lane_data = {4{m_store_data[7:0]}};
            lane_be   = 4'b0001 << m_addr[1:0];
         end
         lsu_pkg::size_half: begin
            lane_data = {2{m_store_data[15:0]}};
            lane_be   = 4'b0011 << {m_addr[1], 1'b0};
         end
         default: begin
            lane_data = m_store_data;
            lane_be   = 4'b1111;
         end
      endcase
   end

   // Entry storage
   always_ff @(posedge clk) begin
      if (wr_en) begin
         entry_addr[wr_ptr] <= m_word_addr;
         entry_data[wr_ptr] <= lane_data;
         entry_be[wr_ptr]   <= lane_be;
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (drain_ack) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, drain_ack})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Both or neither
         endcase
      end
   end

   // ****************************************
   // Forwarding to the m stage load
   // ****************************************

   // Walk from oldest to youngest so the youngest byte is left standing
   always_comb begin
      lsu_pkg::stbuf_ptr_t idx;
      fwd_data    = '0;
      fwd_byte_en = '0;
      for (int i = 0; i < lsu_pkg::STBUF_DEPTH; i++) begin
         idx = rd_ptr + lsu_pkg::stbuf_ptr_t'(i);
         if ((lsu_pkg::stbuf_count_t'(i) < count) && (entry_addr[idx] == m_word_addr)) begin
            for (int b = 0; b < 4; b++) begin
               if (entry_be[idx][b]) begin
                  fwd_data[8*b +: 8] = entry_data[idx][8*b +: 8];
                  fwd_byte_en[b]     = 1'b1;
               end
            end
         end
      end
   end

   // Drain request is always the oldest entry
   assign drain_valid     = count != '0;
   assign drain_word_addr = entry_addr[rd_ptr];
   assign drain_data      = entry_data[rd_ptr];
   assign drain_byte_en   = entry_be[rd_ptr];

   assign stbuf_empty     = count == '0;
   assign lsu_store_stall = count >= lsu_pkg::stbuf_count_t'(lsu_pkg::STBUF_DEPTH - 1);

endmodule

`default_nettype wire

/* lsu_addr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// D stage of the LSU
// Builds the effective address, checks it and hands the request to the m stage
module lsu_addr_gen (
   input  wire logic                  clk,
   input  wire logic                  arst_n,
   input  wire logic                  lsu_valid,
   input  wire logic                  lsu_load,
   input  wire logic                  lsu_store,
   input  lsu_pkg::access_size_t      lsu_size,
   input  wire logic                  lsu_unsign,
   input  lsu_pkg::addr_t             lsu_rs1,
   input  lsu_pkg::offset_t           lsu_offset,
   input  lsu_pkg::data_t             lsu_store_data,
   output logic                       m_valid,
   output logic                       m_load,
   output logic                       m_store,
   output lsu_pkg::access_size_t      m_size,
   output logic                       m_unsign,
   output lsu_pkg::addr_t             m_addr,
   output lsu_pkg::data_t             m_store_data,
   output lsu_pkg::lsu_error_t        m_error
);

   lsu_pkg::addr_t      d_addr;
   lsu_pkg::lsu_error_t d_error;
   logic                d_misaligned;
   logic                d_out_of_range;

   // Base plus sign-extended offset
   assign d_addr = lsu_rs1 + {{20{lsu_offset[11]}}, lsu_offset};

   // ****************************************
   // Address checks
   // ****************************************

   always_comb begin
      d_misaligned = 1'b0;
      case (lsu_size)
         lsu_pkg::size_half: d_misaligned = d_addr[0];
         lsu_pkg::size_word: d_misaligned = |d_addr[1:0];
         default:            d_misaligned = 1'b0;   // Bytes are always aligned
      endcase
   end

   // Upper bits must match the DCCM window
   assign d_out_of_range = d_addr[31:lsu_pkg::DCCM_BITS] !=
                           lsu_pkg::DCCM_BASE[31:lsu_pkg::DCCM_BITS];

   always_comb begin
      if (d_misaligned) begin
         d_error = lsu_pkg::err_misaligned;   // Misalignment wins over range
      end else if (d_out_of_range) begin
         d_error = lsu_pkg::err_range;
      end else begin
         d_error = lsu_pkg::err_none;
      end
   end

   // ****************************************
   // D to M register
   // ****************************************

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         m_valid <= 1'b0;
         m_load  <= 1'b0;
         m_store <= 1'b0;
         m_error <= lsu_pkg::err_none;
      end else begin
         m_valid <= lsu_valid;
         m_load  <= lsu_valid & lsu_load;
         m_store <= lsu_valid & lsu_store;
         m_error <= lsu_valid ? d_error : lsu_pkg::err_none;
      end
   end

   // Request payload, only loaded for a valid request
   always_ff @(posedge clk) begin
      if (lsu_valid) begin
         m_size       <= lsu_size;
         m_unsign     <= lsu_unsign;
         m_addr       <= d_addr;
         m_store_data <= lsu_store_data;
      end
   end

endmodule

`default_nettype wire

/* lsu_dccm_mem.sv */
`timescale 1ns/1ps
`default_nettype none

// DCCM array, one port shared by reads and writes
module lsu_dccm_mem (
   input  wire logic                   clk,
   input  wire logic                   mem_en,
   input  wire logic                   mem_we,
   input  lsu_pkg::dccm_word_addr_t    mem_word_addr,
   input  lsu_pkg::data_t              mem_wdata,
   input  lsu_pkg::byte_en_t           mem_byte_en,
   output lsu_pkg::data_t              mem_rdata
);

   lsu_pkg::data_t mem [lsu_pkg::DCCM_WORDS];

   // ****************************************
   // Array access
   // ****************************************

   always_ff @(posedge clk) begin
      if (mem_en) begin
         if (mem_we) begin
            // Byte lane write
            for (int b = 0; b < 4; b++) begin
               if (mem_byte_en[b]) begin
                  mem[mem_word_addr][8*b +: 8] <= mem_wdata[8*b +: 8];
               end
            end
         end else begin
            mem_rdata <= mem[mem_word_addr];   // Read data valid next cycle
         end
      end
   end

endmodule

`default_nettype wire

/* lsu_pkg.sv */
`default_nettype none

// Shared widths, constants and encodings for the load store unit
package lsu_pkg;

   // ****************************************
   // DCCM geometry
   // ****************************************

   localparam int          DCCM_BITS  = 12;                    // Byte address width, 4 KiB
   localparam int          DCCM_WORDS = 2 ** (DCCM_BITS - 2);  // 32-bit words in the array
   localparam logic [31:0] DCCM_BASE  = 32'hF004_0000;         // Start of the DCCM window

   // ****************************************
   // Store buffer geometry
   // ****************************************

   localparam int STBUF_DEPTH = 4;

   // Plain vector types
   typedef logic [31:0]            addr_t;
   typedef logic [31:0]            data_t;
   typedef logic [3:0]             byte_en_t;         // One enable per byte lane
   typedef logic [DCCM_BITS-3:0]   dccm_word_addr_t;  // Word index inside the DCCM
   typedef logic signed [11:0]     offset_t;
   typedef logic [1:0]             stbuf_ptr_t;
   typedef logic [2:0]             stbuf_count_t;     // Needs one bit more than the pointer

   // Access width of a request
   typedef enum logic [1:0] {
      size_byte,
      size_half,
      size_word
   } access_size_t;

   // Error reported with the result
   typedef enum logic [1:0] {
      err_none,
      err_misaligned,
      err_range
   } lsu_error_t;

endpackage

`default_nettype wire
